// File: files.f
+incdir+common
common/aplic_pkg.sv
logic/aplic_reg_decode.sv
source_cfg/aplic_source_cfg.sv
logic/aplic_ip_bank.sv
logic/aplic_target_cfg.sv
logic/aplic_readback.sv
logic/aplic_domain_regctl.sv
sim/tb_aplic_domain_regctl.sv

// File: sim/tb_aplic_domain_regctl.sv
`include "aplic_consts.svh"
`default_nettype none

module tb_aplic_domain_regctl;
  timeunit 1ns;
  timeprecision 1ps;
  import aplic_pkg::*;

  localparam int RD_TIMEOUT = 20;
  localparam int NSRC       = `APLIC_NR_SRC;

  logic                               i_clk;
  logic                               ni_rst;
  logic                               i_wr_en;
  logic                               i_wr_domain;
  reg_sel_e                           i_wr_sel;
  logic [`APLIC_SRC_IDX_W-1:0]        i_wr_index;
  logic [31:0]                        i_wr_data;
  logic                               i_rd_en;
  logic                               i_rd_domain;
  reg_sel_e                           i_rd_sel;
  logic [`APLIC_SRC_IDX_W-1:0]        i_rd_index;
  logic                               o_rd_valid;
  logic [31:0]                        o_rd_data;
  src_vec_t                           o_setip;
  src_vec_t                           o_setie;
  logic [`APLIC_NR_SRC-1:0][31:0]     o_target;
  src_vec_t                           o_active;
  src_vec_t                           o_intp_domain;
  logic [`APLIC_NR_DOMAINS-1:0]       o_domaincfg_ie;
  logic [`APLIC_NR_DOMAINS-1:0]       o_domaincfg_dm;

  // Reference model state
  logic [31:0] m_dcfg [`APLIC_NR_DOMAINS];
  cfg_t        m_cfg [NSRC];
  logic [31:0] m_tgt [NSRC];
  src_vec_t    m_intp;
  src_vec_t    m_ip;
  src_vec_t    m_ie;

  int          err_count;
  int          timeout_count;
  logic [31:0] rng_state;

  aplic_domain_regctl u_aplic_domain_regctl (
    .i_clk          (i_clk),
    .ni_rst         (ni_rst),
    .i_wr_en        (i_wr_en),
    .i_wr_domain    (i_wr_domain),
    .i_wr_sel       (i_wr_sel),
    .i_wr_index     (i_wr_index),
    .i_wr_data      (i_wr_data),
    .i_rd_en        (i_rd_en),
    .i_rd_domain    (i_rd_domain),
    .i_rd_sel       (i_rd_sel),
    .i_rd_index     (i_rd_index),
    .o_rd_valid     (o_rd_valid),
    .o_rd_data      (o_rd_data),
    .o_setip        (o_setip),
    .o_setie        (o_setie),
    .o_target       (o_target),
    .o_active       (o_active),
    .o_intp_domain  (o_intp_domain),
    .o_domaincfg_ie (o_domaincfg_ie),
    .o_domaincfg_dm (o_domaincfg_dm)
  );

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // ==================================================
  // Reference model
  // ==================================================
  function automatic src_vec_t model_active();
    src_vec_t act;
    act = '0;
    for (int j = 1; j < NSRC; j++) begin
      act[j] = !m_cfg[j][`APLIC_CFG_D_BIT] && (m_cfg[j][2:0] != 3'b000);
    end
    return act;
  endfunction

  function automatic logic [31:0] format_target(input logic dom, input logic [31:0] data);
    logic [31:0] t;
    if (m_dcfg[dom][`APLIC_DCFG_DM_BIT]) begin
      t = data;
      t[11] = 1'b0;
    end else begin
      // Hart index and priority only
      t = {data[31:18], 10'b0, data[7:0]};
      if (data[7:0] == 8'h00) begin
        t[0] = 1'b1;
      end
    end
    return t;
  endfunction

  task automatic model_write(input logic dom, input reg_sel_e sel,
                             input logic [4:0] idx, input logic [31:0] data);
    src_vec_t    owned;
    src_vec_t    act;
    logic [4:0]  num;
    logic        num_ok;
    logic [31:0] dcfg_bits;
    owned     = dom ? m_intp : ~m_intp;
    act       = model_active();
    num       = data[4:0];
    num_ok    = (data[31:5] == '0) && owned[num];
    dcfg_bits = (32'h1 << `APLIC_DCFG_IE_BIT) | (32'h1 << `APLIC_DCFG_DM_BIT) |
                (32'h1 << `APLIC_DCFG_BE_BIT);
    case (sel)
      DOMAINCFG: m_dcfg[dom] = `APLIC_DCFG_RESET | (data & dcfg_bits);
      SOURCECFG: begin
        if (idx != 5'd0 && !dom) begin
          m_intp[idx] = data[`APLIC_CFG_D_BIT];
          m_cfg[idx]  = data[`APLIC_CFG_W-1:0];
        end else if (idx != 5'd0 && m_intp[idx]) begin
          m_cfg[idx] = data[`APLIC_CFG_D_BIT] ? '0 : data[`APLIC_CFG_W-1:0];
        end
      end
      SETIP:    m_ip = m_ip | (data & owned);
      IN_CLRIP: m_ip = m_ip & ~(data & owned);
      SETIPNUM: if (num_ok) m_ip[num] = 1'b1;
      CLRIPNUM: if (num_ok) m_ip[num] = 1'b0;
      SETIE:    m_ie = m_ie | (data & owned);
      CLRIE:    m_ie = m_ie & ~(data & owned);
      SETIENUM: if (num_ok) m_ie[num] = 1'b1;
      CLRIENUM: if (num_ok) m_ie[num] = 1'b0;
      TARGET: begin
        if (m_intp[idx] == dom && act[idx]) begin
          m_tgt[idx] = format_target(dom, data);
        end
      end
      default: ;
    endcase
    m_ip[0] = 1'b0;
    m_ie[0] = 1'b0;
    // An inactive source keeps no enable
    m_ie = m_ie & model_active();
  endtask

  function automatic logic [31:0] model_read(input logic dom, input reg_sel_e sel,
                                             input logic [4:0] idx);
    src_vec_t view;
    view = dom ? m_intp : ~m_intp;
    case (sel)
      DOMAINCFG: return m_dcfg[dom];
      SOURCECFG: begin
        if (view[idx]) return 32'(m_cfg[idx]);
        return dom ? 32'h0 : (32'h1 << `APLIC_CFG_D_BIT);
      end
      SETIP:   return m_ip & view;
      SETIE:   return m_ie & view;
      TARGET:  return view[idx] ? m_tgt[idx] : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  // ==================================================
  // Checks and bus tasks
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  task automatic check_outputs();
    @(negedge i_clk);
    check_value("o_intp_domain", m_intp, o_intp_domain);
    check_value("o_active", model_active(), o_active);
    check_value("o_setip", m_ip, o_setip);
    check_value("o_setie", m_ie, o_setie);
    check_value("o_setie outside o_active", 32'h0, o_setie & ~o_active);
    check_value("o_domaincfg_ie",
                {m_dcfg[1][`APLIC_DCFG_IE_BIT], m_dcfg[0][`APLIC_DCFG_IE_BIT]}, o_domaincfg_ie);
    check_value("o_domaincfg_dm",
                {m_dcfg[1][`APLIC_DCFG_DM_BIT], m_dcfg[0][`APLIC_DCFG_DM_BIT]}, o_domaincfg_dm);
    for (int j = 0; j < NSRC; j++) begin
      check_value($sformatf("o_target[%0d]", j), m_tgt[j], o_target[j]);
    end
  endtask

  // Extra idle edge lets the enable bank follow a new active mask
  task automatic do_write(input logic dom, input reg_sel_e sel,
                          input logic [4:0] idx, input logic [31:0] data);
    @(posedge i_clk);
    i_wr_en     <= 1'b1;
    i_wr_domain <= dom;
    i_wr_sel    <= sel;
    i_wr_index  <= idx;
    i_wr_data   <= data;
    @(posedge i_clk);
    i_wr_en <= 1'b0;
    model_write(dom, sel, idx, data);
    @(posedge i_clk);
  endtask

  // Called one edge after the strobe and samples between edges
  task automatic collect_read(input logic [31:0] exp, input string name);
    int waited;
    waited = 0;
    @(negedge i_clk);
    while (!o_rd_valid && waited < RD_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_rd_valid) begin
      timeout_count++;
      $display("Read of %s got no o_rd_valid within %0d cycles", name, RD_TIMEOUT);
    end else begin
      check_value("o_rd_valid latency in extra cycles", 32'h0, 32'(waited));
      check_value(name, exp, o_rd_data);
      @(negedge i_clk);
      check_value("o_rd_valid after strobe", 32'h0, 32'(o_rd_valid));
    end
  endtask

  task automatic read_check(input logic dom, input reg_sel_e sel, input logic [4:0] idx);
    logic [31:0] exp;
    exp = model_read(dom, sel, idx);
    @(posedge i_clk);
    i_rd_en     <= 1'b1;
    i_rd_domain <= dom;
    i_rd_sel    <= sel;
    i_rd_index  <= idx;
    @(posedge i_clk);
    i_rd_en <= 1'b0;
    collect_read(exp, $sformatf("o_rd_data dom %0d %s[%0d]", dom, sel.name(), idx));
  endtask

  // Read strobe and write strobe on the same edge
  task automatic write_read_same(input logic dom, input reg_sel_e sel,
                                 input logic [4:0] idx, input logic [31:0] data);
    logic [31:0] exp;
    exp = model_read(dom, sel, idx);
    @(posedge i_clk);
    i_wr_en     <= 1'b1;
    i_wr_domain <= dom;
    i_wr_sel    <= sel;
    i_wr_index  <= idx;
    i_wr_data   <= data;
    i_rd_en     <= 1'b1;
    i_rd_domain <= dom;
    i_rd_sel    <= sel;
    i_rd_index  <= idx;
    @(posedge i_clk);
    i_wr_en <= 1'b0;
    i_rd_en <= 1'b0;
    model_write(dom, sel, idx, data);
    collect_read(exp, $sformatf("o_rd_data old value dom %0d %s[%0d]", dom, sel.name(), idx));
  endtask

  task automatic read_sweep();
    for (int d = 0; d < `APLIC_NR_DOMAINS; d++) begin
      read_check(d[0], DOMAINCFG, 5'd0);
      read_check(d[0], SETIP, 5'd0);
      read_check(d[0], SETIE, 5'd0);
      read_check(d[0], IN_CLRIP, 5'd0);
      read_check(d[0], CLRIENUM, 5'd0);
      for (int j = 1; j < NSRC; j++) begin
        read_check(d[0], SOURCECFG, j[4:0]);
        read_check(d[0], TARGET, j[4:0]);
      end
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    logic [31:0] r;
    logic [31:0] data;
    reg_sel_e    sel;
    i_clk       = 1'b0;
    ni_rst      = 1'b0;
    i_wr_en     = 1'b0;
    i_wr_domain = 1'b0;
    i_wr_sel    = DOMAINCFG;
    i_wr_index  = '0;
    i_wr_data   = '0;
    i_rd_en     = 1'b0;
    i_rd_domain = 1'b0;
    i_rd_sel    = DOMAINCFG;
    i_rd_index  = '0;
    err_count     = 0;
    timeout_count = 0;
    rng_state     = 32'he364;
    m_intp = '0;
    m_ip   = '0;
    m_ie   = '0;
    for (int d = 0; d < `APLIC_NR_DOMAINS; d++) begin
      m_dcfg[d] = `APLIC_DCFG_RESET;
    end
    for (int j = 0; j < NSRC; j++) begin
      m_cfg[j] = '0;
      m_tgt[j] = '0;
    end

    repeat (3) @(posedge i_clk);
    ni_rst <= 1'b1;
    @(negedge i_clk);
    check_value("o_rd_valid after reset", 32'h0, 32'(o_rd_valid));
    check_outputs();
    read_sweep();

    // Delegation and sourcecfg
    for (int i = 0; i < 60; i++) begin
      r = lcg_next();
      do_write(r[15], SOURCECFG, r[20:16], r);
      check_outputs();
    end
    read_sweep();

    // Pending bank
    for (int i = 0; i < 80; i++) begin
      r = lcg_next();
      case (r[25:24])
        2'd0:    sel = SETIP;
        2'd1:    sel = IN_CLRIP;
        2'd2:    sel = SETIPNUM;
        default: sel = CLRIPNUM;
      endcase
      data = lcg_next();
      // Half of the numbered writes stay within the source range
      if (r[25] && !r[26]) begin
        data = {27'b0, r[20:16]};
      end
      do_write(r[15], sel, 5'd0, data);
      check_outputs();
    end
    read_sweep();

    // Enable bank with sourcecfg writes that drop active sources
    for (int i = 0; i < 80; i++) begin
      r = lcg_next();
      case (r[25:24])
        2'd0:    sel = SETIE;
        2'd1:    sel = CLRIE;
        2'd2:    sel = SETIENUM;
        default: sel = CLRIENUM;
      endcase
      data = lcg_next();
      if (r[25] && !r[26]) begin
        data = {27'b0, r[20:16]};
      end
      do_write(r[15], sel, 5'd0, data);
      if (i % 8 == 7) begin
        data = lcg_next();
        do_write(data[15], SOURCECFG, data[20:16], data);
      end
      check_outputs();
    end
    read_sweep();

    // Delivery mode then target formatting
    for (int i = 0; i < 12; i++) begin
      r = lcg_next();
      do_write(r[15], DOMAINCFG, 5'd0, lcg_next());
      for (int k = 0; k < 6; k++) begin
        r = lcg_next();
        data = lcg_next();
        if (k == 0) data[7:0] = 8'h00;
        do_write(r[15], TARGET, r[20:16], data);
      end
      check_outputs();
    end
    read_sweep();

    // Same-cycle read and write
    for (int i = 0; i < 24; i++) begin
      r = lcg_next();
      case (r[26:24])
        3'd0:    sel = DOMAINCFG;
        3'd1:    sel = SOURCECFG;
        3'd2:    sel = SETIP;
        3'd3:    sel = SETIE;
        default: sel = TARGET;
      endcase
      write_read_same(r[15], sel, r[20:16], lcg_next());
      read_check(r[15], sel, r[20:16]);
    end
    check_outputs();

    $display("Errors: %0d failed checks, %0d read timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/aplic_domain_regctl.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_domain_regctl (
  input  logic                            i_clk,
  input  logic                            ni_rst,
  // Write strobe
  input  logic                            i_wr_en,
  input  logic                            i_wr_domain,
  input  aplic_pkg::reg_sel_e             i_wr_sel,
  input  logic [`APLIC_SRC_IDX_W-1:0]     i_wr_index,
  input  logic [31:0]                     i_wr_data,
  // Read strobe
  input  logic                            i_rd_en,
  input  logic                            i_rd_domain,
  input  aplic_pkg::reg_sel_e             i_rd_sel,
  input  logic [`APLIC_SRC_IDX_W-1:0]     i_rd_index,
  output logic                            o_rd_valid,
  output logic [31:0]                     o_rd_data,
  // State towards the notifier
  output aplic_pkg::src_vec_t             o_setip,
  output aplic_pkg::src_vec_t             o_setie,
  output logic [`APLIC_NR_SRC-1:0][31:0]  o_target,
  output aplic_pkg::src_vec_t             o_active,
  output aplic_pkg::src_vec_t             o_intp_domain,
  output logic [`APLIC_NR_DOMAINS-1:0]    o_domaincfg_ie,
  output logic [`APLIC_NR_DOMAINS-1:0]    o_domaincfg_dm
);
  import aplic_pkg::*;

  ip_op_e                             ip_op;
  ip_op_e                             ie_op;
  src_vec_t                           ip_mask;
  src_vec_t                           ie_mask;
  logic [`APLIC_SRC_IDX_W-1:0]        ip_num;
  logic [`APLIC_SRC_IDX_W-1:0]        ie_num;
  logic                               dcfg_we;
  logic                               cfg_we;
  logic                               tgt_we;
  logic                               wr_domain;
  logic [`APLIC_SRC_IDX_W-1:0]        wr_index;
  logic [31:0]                        wr_data;
  logic [`APLIC_NR_DOMAINS-1:0][31:0] domaincfg;
  cfg_t [`APLIC_NR_SRC-1:0]           sourcecfg;

  // ================================================
  // Input side
  // ================================================
  aplic_reg_decode u_reg_decode (
    .i_wr_en     (i_wr_en),
    .i_wr_domain (i_wr_domain),
    .i_wr_sel    (i_wr_sel),
    .i_wr_index  (i_wr_index),
    .i_wr_data   (i_wr_data),
    .o_ip_op     (ip_op),
    .o_ip_mask   (ip_mask),
    .o_ip_num    (ip_num),
    .o_ie_op     (ie_op),
    .o_ie_mask   (ie_mask),
    .o_ie_num    (ie_num),
    .o_dcfg_we   (dcfg_we),
    .o_cfg_we    (cfg_we),
    .o_tgt_we    (tgt_we),
    .o_wr_domain (wr_domain),
    .o_wr_index  (wr_index),
    .o_wr_data   (wr_data)
  );

  // ================================================
  // Processing
  // ================================================
  aplic_source_cfg u_source_cfg (
    .i_clk          (i_clk),
    .ni_rst         (ni_rst),
    .i_dcfg_we      (dcfg_we),
    .i_cfg_we       (cfg_we),
    .i_wr_domain    (wr_domain),
    .i_wr_index     (wr_index),
    .i_wr_data      (wr_data),
    .o_domaincfg    (domaincfg),
    .o_sourcecfg    (sourcecfg),
    .o_intp_domain  (o_intp_domain),
    .o_active       (o_active),
    .o_domaincfg_ie (o_domaincfg_ie),
    .o_domaincfg_dm (o_domaincfg_dm)
  );

  aplic_ip_bank #(
    .GATE_ACTIVE (1'b0)
  ) u_pending (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_op          (ip_op),
    .i_mask        (ip_mask),
    .i_num         (ip_num),
    .i_wr_domain   (wr_domain),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .o_bits        (o_setip)
  );

  aplic_ip_bank #(
    .GATE_ACTIVE (1'b1)
  ) u_enable (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_op          (ie_op),
    .i_mask        (ie_mask),
    .i_num         (ie_num),
    .i_wr_domain   (wr_domain),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .o_bits        (o_setie)
  );

  aplic_target_cfg u_target_cfg (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_tgt_we      (tgt_we),
    .i_wr_domain   (wr_domain),
    .i_wr_index    (wr_index),
    .i_wr_data     (wr_data),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .i_domaincfg   (domaincfg),
    .o_target      (o_target)
  );

  // ================================================
  // Output side
  // ================================================
  aplic_readback u_readback (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_rd_en       (i_rd_en),
    .i_rd_domain   (i_rd_domain),
    .i_rd_sel      (i_rd_sel),
    .i_rd_index    (i_rd_index),
    .i_domaincfg   (domaincfg),
    .i_sourcecfg   (sourcecfg),
    .i_intp_domain (o_intp_domain),
    .i_setip       (o_setip),
    .i_setie       (o_setie),
    .i_target      (o_target),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data)
  );

endmodule

`default_nettype wire

// File: logic/aplic_readback.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_readback (
  input  logic                                i_clk,
  input  logic                                ni_rst,
  input  logic                                i_rd_en,
  input  logic                                i_rd_domain,
  input  aplic_pkg::reg_sel_e                 i_rd_sel,
  input  logic [`APLIC_SRC_IDX_W-1:0]         i_rd_index,
  input  logic [`APLIC_NR_DOMAINS-1:0][31:0]  i_domaincfg,
  input  aplic_pkg::cfg_t [`APLIC_NR_SRC-1:0] i_sourcecfg,
  input  aplic_pkg::src_vec_t                 i_intp_domain,
  input  aplic_pkg::src_vec_t                 i_setip,
  input  aplic_pkg::src_vec_t                 i_setie,
  input  logic [`APLIC_NR_SRC-1:0][31:0]      i_target,
  output logic                                o_rd_valid,
  output logic [31:0]                         o_rd_data
);
  import aplic_pkg::*;

  src_vec_t    view;
  logic        owned;
  logic [31:0] rd_word;

  // Sources the reading domain owns
  assign view  = i_rd_domain ? i_intp_domain : ~i_intp_domain;
  assign owned = view[i_rd_index];

  // ================================================
  // Per-domain view
  // ================================================
  always_comb begin
    rd_word = '0;
    case (i_rd_sel)
      DOMAINCFG: rd_word = i_domaincfg[i_rd_domain];
      SOURCECFG: begin
        if (owned) begin
          rd_word = 32'(i_sourcecfg[i_rd_index]);
        end else if (!i_rd_domain) begin
          // Machine sees only that the source went to supervisor
          rd_word = 32'h1 << `APLIC_CFG_D_BIT;
        end
      end
      SETIP:  rd_word = i_setip & view;
      SETIE:  rd_word = i_setie & view;
      TARGET: rd_word = owned ? i_target[i_rd_index] : '0;
      // Numbered registers, in_clrip and clrie read as zero
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_en;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: logic/aplic_target_cfg.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_target_cfg (
  input  logic                               i_clk,
  input  logic                               ni_rst,
  input  logic                               i_tgt_we,
  input  logic                               i_wr_domain,
  input  logic [`APLIC_SRC_IDX_W-1:0]        i_wr_index,
  input  logic [31:0]                        i_wr_data,
  input  aplic_pkg::src_vec_t                i_intp_domain,
  input  aplic_pkg::src_vec_t                i_active,
  input  logic [`APLIC_NR_DOMAINS-1:0][31:0] i_domaincfg,
  output logic [`APLIC_NR_SRC-1:0][31:0]     o_target
);

  logic [`APLIC_NR_SRC-1:0][31:0] target_q;
  logic                           wr_ok;
  logic                           msi_mode;
  logic [`APLIC_TGT_PRIO_W-1:0]   prio;
  logic [31:0]                    tgt_fmt;

  // Only the owner of an active source may place it
  assign wr_ok = i_tgt_we && (i_intp_domain[i_wr_index] == i_wr_domain) &&
                 i_active[i_wr_index];

  assign msi_mode = i_domaincfg[i_wr_domain][`APLIC_DCFG_DM_BIT];
  assign prio     = i_wr_data[`APLIC_TGT_PRIO_W-1:0];

  // Direct mode keeps hart index and priority, MSI mode all but bit 11
  always_comb begin
    if (msi_mode) begin
      tgt_fmt = i_wr_data & `APLIC_TGT_MSI_KEEP;
    end else begin
      tgt_fmt = i_wr_data & `APLIC_TGT_DIRECT_KEEP;
      // Priority 0 is reserved and maps to 1
      if (prio == '0) begin
        tgt_fmt[0] = 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      target_q <= '0;
    end else if (wr_ok) begin
      target_q[i_wr_index] <= tgt_fmt;
    end
  end

  assign o_target = target_q;

endmodule

`default_nettype wire

// File: logic/aplic_ip_bank.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_ip_bank #(
  parameter bit GATE_ACTIVE = 1'b0
) (
  input  logic                        i_clk,
  input  logic                        ni_rst,
  input  aplic_pkg::ip_op_e           i_op,
  input  aplic_pkg::src_vec_t         i_mask,
  input  logic [`APLIC_SRC_IDX_W-1:0] i_num,
  input  logic                        i_wr_domain,
  input  aplic_pkg::src_vec_t         i_intp_domain,
  input  aplic_pkg::src_vec_t         i_active,
  output aplic_pkg::src_vec_t         o_bits
);
  import aplic_pkg::*;

  src_vec_t bits_q;
  src_vec_t bits_d;
  src_vec_t owned;
  src_vec_t wr_bits;

  // Sources the writing domain may touch
  assign owned   = i_wr_domain ? i_intp_domain : ~i_intp_domain;
  assign wr_bits = i_mask & owned;

  always_comb begin
    bits_d = bits_q;
    case (i_op)
      OP_SETIX: bits_d = bits_q | wr_bits;
      OP_CLRIX: bits_d = bits_q & ~wr_bits;
      OP_SETIXNUM: begin
        if (owned[i_num]) begin
          bits_d[i_num] = 1'b1;
        end
      end
      OP_CLRIXNUM: begin
        if (owned[i_num]) begin
          bits_d[i_num] = 1'b0;
        end
      end
      default: bits_d = bits_q;
    endcase

    // Slot 0 is no source
    bits_d[0] = 1'b0;

    // Enables drop as soon as their source goes inactive
    if (GATE_ACTIVE) begin
      bits_d = bits_d & i_active;
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      bits_q <= '0;
    end else begin
      bits_q <= bits_d;
    end
  end

  assign o_bits = bits_q;

endmodule

`default_nettype wire

// File: source_cfg/aplic_source_cfg.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_source_cfg (
  input  logic                                i_clk,
  input  logic                                ni_rst,
  input  logic                                i_dcfg_we,
  input  logic                                i_cfg_we,
  input  logic                                i_wr_domain,
  input  logic [`APLIC_SRC_IDX_W-1:0]         i_wr_index,
  input  logic [31:0]                         i_wr_data,
  output logic [`APLIC_NR_DOMAINS-1:0][31:0]  o_domaincfg,
  output aplic_pkg::cfg_t [`APLIC_NR_SRC-1:0] o_sourcecfg,
  output aplic_pkg::src_vec_t                 o_intp_domain,
  output aplic_pkg::src_vec_t                 o_active,
  output logic [`APLIC_NR_DOMAINS-1:0]        o_domaincfg_ie,
  output logic [`APLIC_NR_DOMAINS-1:0]        o_domaincfg_dm
);
  import aplic_pkg::*;

  // Writable domaincfg bits
  localparam logic [31:0] DCFG_KEEP = (32'h1 << `APLIC_DCFG_IE_BIT) |
                                      (32'h1 << `APLIC_DCFG_DM_BIT) |
                                      (32'h1 << `APLIC_DCFG_BE_BIT);

  logic [`APLIC_NR_DOMAINS-1:0][31:0] domaincfg_q;
  cfg_t [`APLIC_NR_SRC-1:0]           sourcecfg_q;
  src_vec_t                           intp_domain_q;
  cfg_t                               wr_cfg;
  logic                               wr_d_bit;
  logic                               cfg_wr_ok;

  assign wr_cfg   = i_wr_data[`APLIC_CFG_W-1:0];
  assign wr_d_bit = wr_cfg[`APLIC_CFG_D_BIT];

  // Machine reaches every source, supervisor only the delegated ones
  assign cfg_wr_ok = i_cfg_we && (i_wr_index != '0) &&
                     (!i_wr_domain || intp_domain_q[i_wr_index]);

  // ================================================
  // domaincfg
  // ================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      domaincfg_q <= {`APLIC_NR_DOMAINS{`APLIC_DCFG_RESET}};
    end else if (i_dcfg_we) begin
      domaincfg_q[i_wr_domain] <= `APLIC_DCFG_RESET | (i_wr_data & DCFG_KEEP);
    end
  end

  always_comb begin
    for (int d = 0; d < `APLIC_NR_DOMAINS; d++) begin
      o_domaincfg_ie[d] = domaincfg_q[d][`APLIC_DCFG_IE_BIT];
      o_domaincfg_dm[d] = domaincfg_q[d][`APLIC_DCFG_DM_BIT];
    end
  end

  // ================================================
  // sourcecfg and ownership
  // ================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      sourcecfg_q   <= '0;
      intp_domain_q <= '0;
    end else if (cfg_wr_ok) begin
      if (!i_wr_domain) begin
        intp_domain_q[i_wr_index] <= wr_d_bit;
        sourcecfg_q[i_wr_index]   <= wr_cfg;
      end else begin
        // Supervisor has no child domain to delegate to
        sourcecfg_q[i_wr_index] <= wr_d_bit ? '0 : wr_cfg;
      end
    end
  end

  // Active means not delegated and a nonzero source mode
  always_comb begin
    o_active = '0;
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      o_active[j] = !sourcecfg_q[j][`APLIC_CFG_D_BIT] && (sourcecfg_q[j][2:0] != 3'b000);
    end
  end

  assign o_domaincfg   = domaincfg_q;
  assign o_sourcecfg   = sourcecfg_q;
  assign o_intp_domain = intp_domain_q;

endmodule

`default_nettype wire

// File: logic/aplic_reg_decode.sv
`include "aplic_consts.svh"
`default_nettype none

module aplic_reg_decode (
  input  logic                        i_wr_en,
  input  logic                        i_wr_domain,
  input  aplic_pkg::reg_sel_e         i_wr_sel,
  input  logic [`APLIC_SRC_IDX_W-1:0] i_wr_index,
  input  logic [31:0]                 i_wr_data,
  output aplic_pkg::ip_op_e           o_ip_op,
  output aplic_pkg::src_vec_t         o_ip_mask,
  output logic [`APLIC_SRC_IDX_W-1:0] o_ip_num,
  output aplic_pkg::ip_op_e           o_ie_op,
  output aplic_pkg::src_vec_t         o_ie_mask,
  output logic [`APLIC_SRC_IDX_W-1:0] o_ie_num,
  output logic                        o_dcfg_we,
  output logic                        o_cfg_we,
  output logic                        o_tgt_we,
  output logic                        o_wr_domain,
  output logic [`APLIC_SRC_IDX_W-1:0] o_wr_index,
  output logic [31:0]                 o_wr_data
);
  import aplic_pkg::*;

  logic num_in_range;

  // A number past the last source selects nothing
  assign num_in_range = (i_wr_data[31:`APLIC_SRC_IDX_W] == '0);

  // Bit-vector writes reach the banks as a mask, numbered ones as an index
  assign o_ip_mask = i_wr_data;
  assign o_ie_mask = i_wr_data;
  assign o_ip_num  = i_wr_data[`APLIC_SRC_IDX_W-1:0];
  assign o_ie_num  = i_wr_data[`APLIC_SRC_IDX_W-1:0];

  assign o_wr_domain = i_wr_domain;
  assign o_wr_index  = i_wr_index;
  assign o_wr_data   = i_wr_data;

  // ================================================
  // Register select to operation
  // ================================================
  always_comb begin
    o_ip_op   = OP_HOLD;
    o_ie_op   = OP_HOLD;
    o_dcfg_we = 1'b0;
    o_cfg_we  = 1'b0;
    o_tgt_we  = 1'b0;
    if (i_wr_en) begin
      case (i_wr_sel)
        DOMAINCFG: o_dcfg_we = 1'b1;
        SOURCECFG: o_cfg_we  = 1'b1;
        TARGET:    o_tgt_we  = 1'b1;
        SETIP:     o_ip_op   = OP_SETIX;
        IN_CLRIP:  o_ip_op   = OP_CLRIX;
        SETIPNUM:  o_ip_op   = num_in_range ? OP_SETIXNUM : OP_HOLD;
        CLRIPNUM:  o_ip_op   = num_in_range ? OP_CLRIXNUM : OP_HOLD;
        SETIE:     o_ie_op   = OP_SETIX;
        CLRIE:     o_ie_op   = OP_CLRIX;
        SETIENUM:  o_ie_op   = num_in_range ? OP_SETIXNUM : OP_HOLD;
        CLRIENUM:  o_ie_op   = num_in_range ? OP_CLRIXNUM : OP_HOLD;
        default:   o_ip_op   = OP_HOLD;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: common/aplic_pkg.sv
`include "aplic_consts.svh"
`default_nettype none

package aplic_pkg;

  // Register being accessed by a write or a read
  typedef enum logic [3:0] {
    DOMAINCFG,
    SOURCECFG,
    SETIP,
    SETIPNUM,
    IN_CLRIP,
    CLRIPNUM,
    SETIE,
    SETIENUM,
    CLRIE,
    CLRIENUM,
    TARGET
  } reg_sel_e;

  // Operation applied to a pending or enable bank
  typedef enum logic [2:0] {
    OP_HOLD,
    OP_SETIX,
    OP_CLRIX,
    OP_SETIXNUM,
    OP_CLRIXNUM
  } ip_op_e;

  // One bit per source with bit 0 unused
  typedef logic [`APLIC_NR_SRC-1:0] src_vec_t;

  // One sourcecfg entry
  typedef logic [`APLIC_CFG_W-1:0] cfg_t;

endpackage

`default_nettype wire

// File: common/aplic_consts.svh
`ifndef APLIC_CONSTS_SVH
`define APLIC_CONSTS_SVH
`default_nettype none

// Source slots including the unused slot 0
`define APLIC_NR_SRC          32
`define APLIC_NR_DOMAINS      2
`define APLIC_SRC_IDX_W       5

// sourcecfg layout
`define APLIC_CFG_W           11
`define APLIC_CFG_D_BIT       10

// domaincfg layout
`define APLIC_DCFG_IE_BIT     8
`define APLIC_DCFG_DM_BIT     2
`define APLIC_DCFG_BE_BIT     0
`define APLIC_DCFG_RESET      32'h80000000

// target fields kept per delivery mode
`define APLIC_TGT_PRIO_W      8
`define APLIC_TGT_DIRECT_KEEP 32'hfffc00ff
`define APLIC_TGT_MSI_KEEP    32'hfffff7ff

`default_nettype wire
`endif
